// ==== Makefile ====
TOP := tb_pcie_tlp_bridge

.PHONY: all build lint clean

all: build
	obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || { echo "Simulation did not complete"; exit 1; }
	@echo "Simulation finished"

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module pcie_tlp_bridge

clean:
	rm -rf obj_dir sim.log

// ==== logic/link_status_ctrl.sv ====
// ------------------------------------------------
// Combines reset sources and drives the status LED
// LED is steady on with link up, blinks otherwise
// ------------------------------------------------

`timescale 1ns/1ns
`include "tlp_settings.svh"

module link_status_ctrl (
    input  logic clk_pcie,
    input  logic rst,
    input  logic link_up,
    input  logic user_reset,
    input  logic subsys_reset_req,
    output logic subsys_rst,
    output logic led_state
);

    // Free-running blink counter
    logic [`LED_BLINK_BIT:0] blink_cnt;

    // ------------------------------------------------
    // Datapath reset
    // ------------------------------------------------

    // Any source holds both paths in reset, one cycle late
    always_ff @(posedge clk_pcie) begin
        subsys_rst <= rst || user_reset || subsys_reset_req;
    end

    // ------------------------------------------------
    // Status LED
    // ------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    assign led_state = link_up || blink_cnt[`LED_BLINK_BIT];

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------

    // Top-level reset always reaches the datapaths
    a_rst_to_subsys: assert property (@(posedge clk_pcie)
        rst |=> subsys_rst)
        else $error("subsys_rst missed a reset");

endmodule

// ==== logic/pcie_tlp_bridge.sv ====
// ------------------------------------------------
// Top level of the 128-bit to 64-bit PCIe TLP bridge
// Sits between the TLP stream and the core user interface
// ------------------------------------------------

`timescale 1ns/1ns

module pcie_tlp_bridge
    import tlp_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,

    // Core status and reset requests
    input  logic          link_up,
    input  logic          user_reset,
    input  logic          subsys_reset_req,

    // 128-bit transmit stream in
    input  tlps_beat_t    tlps_tx,
    input  logic          tlps_tx_valid,
    output logic          tlps_tx_ready,

    // 64-bit core transmit out
    output core_tx_beat_t core_tx,
    output logic          core_tx_valid,
    input  logic          core_tx_ready,

    // 64-bit core receive in, no back-pressure
    input  core_rx_beat_t core_rx,
    input  logic          core_rx_valid,

    // 128-bit receive stream out
    output tlps_beat_t    tlps_rx,
    output logic          tlps_rx_valid,

    output logic          led_state
);

    logic subsys_rst;

    link_status_ctrl i_link_status_ctrl (
        .clk_pcie         (clk_pcie),
        .rst              (rst),
        .link_up          (link_up),
        .user_reset       (user_reset),
        .subsys_reset_req (subsys_reset_req),
        .subsys_rst       (subsys_rst),
        .led_state        (led_state)
    );

    tlp_tx_narrow i_tlp_tx_narrow (
        .clk_pcie      (clk_pcie),
        .rst           (subsys_rst),
        .tlps_in       (tlps_tx),
        .tlps_in_valid (tlps_tx_valid),
        .tlps_in_ready (tlps_tx_ready),
        .core_tx       (core_tx),
        .core_tx_valid (core_tx_valid),
        .core_tx_ready (core_tx_ready)
    );

    tlp_rx_widen i_tlp_rx_widen (
        .clk_pcie       (clk_pcie),
        .rst            (subsys_rst),
        .core_rx        (core_rx),
        .core_rx_valid  (core_rx_valid),
        .tlps_out       (tlps_rx),
        .tlps_out_valid (tlps_rx_valid)
    );

endmodule

// ==== logic/tlp_pkg.sv ====
// ------------------------------------------------
// Shared beat types for both stream directions
// Import with a wildcard import in the module header
// ------------------------------------------------

`include "tlp_settings.svh"

package tlp_pkg;

    // ------------------------------------------------
    // 128-bit data word
    // ------------------------------------------------

    // Receive side packs dwords, transmit side sends qwords
    typedef union packed {
        logic [`TLPS_DW_COUNT-1:0][`DW_WIDTH-1:0]                         dw;
        logic [`TLPS_DW_COUNT/`CORE_DW_COUNT-1:0][`CORE_DW_COUNT*`DW_WIDTH-1:0] qw;
    } tlps_data_u;

    // Same bit order as the core tuser field, first at bit 0
    typedef struct packed {
        logic [`BAR_HIT_WIDTH-1:0] bar_hit;
        logic                      last;
        logic                      first;
    } tlps_user_t;

    // One 128-bit TLP stream beat
    typedef struct packed {
        tlps_data_u                data;
        logic [`TLPS_DW_COUNT-1:0] keepdw;
        logic                      last;
        tlps_user_t                user;
    } tlps_beat_t;

    // ------------------------------------------------
    // 64-bit core beats
    // ------------------------------------------------

    // Transmit beat toward the core, byte keep
    typedef struct packed {
        logic [`CORE_DW_COUNT*`DW_WIDTH-1:0]   data;
        logic [`CORE_DW_COUNT*`DW_WIDTH/8-1:0] keep;
        logic                                  last;
    } core_tx_beat_t;

    // Receive beat from the core
    typedef struct packed {
        logic [`CORE_DW_COUNT*`DW_WIDTH-1:0]   data;
        logic [`CORE_DW_COUNT*`DW_WIDTH/8-1:0] keep;
        logic                                  last;
        logic [`BAR_HIT_WIDTH-1:0]             bar_hit;
    } core_rx_beat_t;

endpackage

// ==== logic/tlp_rx_widen.sv ====
// ------------------------------------------------
// Gathers 64-bit core receive beats into 128-bit beats
// Output has no back-pressure and is valid for one cycle
// ------------------------------------------------

`timescale 1ns/1ns
`include "tlp_settings.svh"

module tlp_rx_widen
    import tlp_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,
    input  core_rx_beat_t core_rx,
    input  logic          core_rx_valid,
    output tlps_beat_t    tlps_out,
    output logic          tlps_out_valid
);

    localparam int LEN_WIDTH = $clog2(`TLPS_DW_COUNT + 1);
    localparam int IDX_WIDTH = $clog2(`TLPS_DW_COUNT);

    // Gathered beat under construction
    tlps_data_u                data_q;
    logic [LEN_WIDTH-1:0]      len_q;
    logic                      first_q;
    logic                      last_q;
    logic [`BAR_HIT_WIDTH-1:0] bar_hit_q;

    logic                 out_valid;
    logic                 two_dw;
    logic [LEN_WIDTH-1:0] base;
    logic [LEN_WIDTH-1:0] next_len;
    logic [IDX_WIDTH-1:0] base_idx;

    // keep bit of the second dword
    assign two_dw = core_rx.keep[`DW_WIDTH/8];

    // Full once more than one core beat worth is held, or on packet end
    assign out_valid = last_q || (len_q > LEN_WIDTH'(`CORE_DW_COUNT));

    // A beat arriving while the output shows restarts at dword 0
    assign base     = out_valid ? '0 : len_q;
    assign next_len = base + LEN_WIDTH'(1) + LEN_WIDTH'(two_dw);
    assign base_idx = base[IDX_WIDTH-1:0];

    always_comb begin
        tlps_out.data = data_q;
        for (int i = 0; i < `TLPS_DW_COUNT; i++) begin
            tlps_out.keepdw[i] = (len_q > LEN_WIDTH'(i));
        end
        tlps_out.last         = last_q;
        tlps_out.user.first   = first_q;
        tlps_out.user.last    = last_q;
        tlps_out.user.bar_hit = bar_hit_q;
        tlps_out_valid        = out_valid;
    end

    // ------------------------------------------------
    // Dword packing
    // ------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (core_rx_valid) begin
            data_q.dw[base_idx] <= core_rx.data[`DW_WIDTH-1:0];
            if (two_dw) begin
                data_q.dw[base_idx + IDX_WIDTH'(1)] <= core_rx.data[2*`DW_WIDTH-1:`DW_WIDTH];
            end
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            first_q   <= 1'b1;
            last_q    <= 1'b0;
            len_q     <= '0;
            bar_hit_q <= '0;
        end else if (core_rx_valid) begin
            // Next beat is a packet start only after a last beat left
            first_q   <= out_valid ? last_q : first_q;
            last_q    <= core_rx.last;
            len_q     <= next_len;
            bar_hit_q <= core_rx.bar_hit;
        end else if (out_valid) begin
            first_q   <= last_q;
            last_q    <= 1'b0;
            len_q     <= '0;
            bar_hit_q <= '0;
        end
    end

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------

    // An emitted beat always carries at least dword 0
    a_keepdw0: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_out_valid |-> tlps_out.keepdw[0])
        else $error("tlps_out valid with empty keepdw");

endmodule

// ==== logic/tlp_settings.svh ====
// ------------------------------------------------
// Bus widths and constants for the TLP bridge
// Included by the package and the RTL that needs them
// ------------------------------------------------

`ifndef TLP_SETTINGS_SVH
`define TLP_SETTINGS_SVH

// Width of one dword in bits
`define DW_WIDTH 32

// Dwords carried by one 128-bit TLP stream beat
`define TLPS_DW_COUNT 4

// Dwords carried by one 64-bit core beat
`define CORE_DW_COUNT 2

// BAR-hit flags reported by the core
`define BAR_HIT_WIDTH 7

// Counter bit that blinks the LED while the link is down
`define LED_BLINK_BIT 25

`endif

// ==== logic/tlp_tx_narrow.sv ====
// ------------------------------------------------
// Splits 128-bit transmit beats into 64-bit core beats
// Narrow beats pass through, wide beats take two core beats
// ------------------------------------------------

`timescale 1ns/1ns
`include "tlp_settings.svh"

module tlp_tx_narrow
    import tlp_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,
    input  tlps_beat_t    tlps_in,
    input  logic          tlps_in_valid,
    output logic          tlps_in_ready,
    output core_tx_beat_t core_tx,
    output logic          core_tx_valid,
    input  logic          core_tx_ready
);

    localparam int QW_WIDTH   = `CORE_DW_COUNT * `DW_WIDTH;
    localparam int KEEP_WIDTH = QW_WIDTH / 8;

    localparam logic [KEEP_WIDTH-1:0] KEEP_FULL = {KEEP_WIDTH{1'b1}};
    localparam logic [KEEP_WIDTH-1:0] KEEP_LOW  =
        {{(KEEP_WIDTH/2){1'b0}}, {(KEEP_WIDTH/2){1'b1}}};

    // Upper half of a wide beat waiting for its turn
    logic                hold_valid;
    logic [QW_WIDTH-1:0] hold_data;
    logic                hold_dw3;
    logic                hold_last;

    logic wide_beat;

    assign wide_beat = tlps_in.keepdw[2];

    always_comb begin
        core_tx_valid = hold_valid || tlps_in_valid;
        if (hold_valid) begin
            core_tx.data = hold_data;
            core_tx.keep = hold_dw3 ? KEEP_FULL : KEEP_LOW;
            core_tx.last = hold_last;
        end else begin
            core_tx.data = tlps_in.data.qw[0];
            core_tx.keep = tlps_in.keepdw[1] ? KEEP_FULL : KEEP_LOW;
            core_tx.last = tlps_in.last && !wide_beat;
        end
        // Wide beat is taken only as its upper half leaves
        tlps_in_ready = core_tx_ready && (hold_valid || !wide_beat);
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (core_tx_valid && core_tx_ready) begin
            hold_valid <= !hold_valid && tlps_in_valid && wide_beat;
        end
    end

    // Capture upper qword as the low qword goes out
    always_ff @(posedge clk_pcie) begin
        if (!hold_valid && tlps_in_valid && wide_beat && core_tx_ready) begin
            hold_data <= tlps_in.data.qw[1];
            hold_dw3  <= tlps_in.keepdw[3];
            hold_last <= tlps_in.last;
        end
    end

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------

    a_core_tx_stable: assert property (@(posedge clk_pcie) disable iff (rst)
        core_tx_valid && !core_tx_ready |=> core_tx_valid && $stable(core_tx))
        else $error("core_tx changed while stalled");

    a_keepdw_contig: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_in_valid |-> tlps_in.keepdw inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else $error("tlps_in keepdw not contiguous");

endmodule

// ==== project.f ====
+incdir+logic
logic/tlp_pkg.sv
logic/tlp_tx_narrow.sv
logic/tlp_rx_widen.sv
logic/link_status_ctrl.sv
logic/pcie_tlp_bridge.sv
tests/tb_pcie_tlp_bridge.sv

// ==== tests/tb_pcie_tlp_bridge.sv ====
// ------------------------------------------------
// Self-checking testbench for the PCIe TLP bridge
// LFSR stimulus checked against models of both paths
// ------------------------------------------------

`timescale 1ns/1ns
`include "tlp_settings.svh"

module tb_pcie_tlp_bridge
    import tlp_pkg::*;
();

    logic          clk_pcie;
    logic          rst;
    logic          link_up;
    logic          user_reset;
    logic          subsys_reset_req;
    tlps_beat_t    tlps_tx;
    logic          tlps_tx_valid;
    logic          tlps_tx_ready;
    core_tx_beat_t core_tx;
    logic          core_tx_valid;
    logic          core_tx_ready;
    core_rx_beat_t core_rx;
    logic          core_rx_valid;
    tlps_beat_t    tlps_rx;
    logic          tlps_rx_valid;
    logic          led_state;

    int unsigned checks;
    int unsigned errors;
    int unsigned tests;
    logic [15:0] lfsr;

    // Receive model state and the beat due on the next cycle
    tlps_data_u    m_data;
    int            m_len;
    logic          m_first;
    logic          exp_valid;
    tlps_beat_t    exp_beat;
    core_tx_beat_t tx_exp_q[$];

    always #10 clk_pcie = ~clk_pcie;

    pcie_tlp_bridge i_pcie_tlp_bridge (
        .clk_pcie         (clk_pcie),
        .rst              (rst),
        .link_up          (link_up),
        .user_reset       (user_reset),
        .subsys_reset_req (subsys_reset_req),
        .tlps_tx          (tlps_tx),
        .tlps_tx_valid    (tlps_tx_valid),
        .tlps_tx_ready    (tlps_tx_ready),
        .core_tx          (core_tx),
        .core_tx_valid    (core_tx_valid),
        .core_tx_ready    (core_tx_ready),
        .core_rx          (core_rx),
        .core_rx_valid    (core_rx_valid),
        .tlps_rx          (tlps_rx),
        .tlps_rx_valid    (tlps_rx_valid),
        .led_state        (led_state)
    );

    // ------------------------------------------------
    // Random source and checking
    // ------------------------------------------------

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[126:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int unsigned err_start);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - err_start);
    endtask

    task automatic clear_rx_model();
        m_data  = '0;
        m_len   = 0;
        m_first = 1'b1;
    endtask

    // ------------------------------------------------
    // Receive path driver and model
    // ------------------------------------------------

    // One clock of core receive input, checked one cycle later
    task automatic rx_cycle(input logic valid, input int ndw, input logic [63:0] data,
                            input logic last, input logic [6:0] bar_hit,
                            input logic [1:0] req);
        logic [127:0] mask;
        tlps_beat_t   next_beat;
        logic         next_valid;
        @(posedge clk_pcie);
        core_rx_valid    <= valid;
        core_rx.data     <= data;
        core_rx.keep     <= (ndw == 2) ? 8'hff : 8'h0f;
        core_rx.last     <= last;
        core_rx.bar_hit  <= bar_hit;
        subsys_reset_req <= req[0];
        user_reset       <= req[1];
        next_valid = 1'b0;
        next_beat  = '0;
        if (valid) begin
            m_data.dw[m_len] = data[31:0];
            if (ndw == 2) begin
                m_data.dw[m_len + 1] = data[63:32];
            end
            m_len = m_len + ndw;
            // Three dwords or a packet end completes a wide beat
            if (m_len >= 3 || last) begin
                next_valid             = 1'b1;
                next_beat.data         = m_data;
                next_beat.keepdw       = 4'((1 << m_len) - 1);
                next_beat.last         = last;
                next_beat.user.first   = m_first;
                next_beat.user.last    = last;
                next_beat.user.bar_hit = bar_hit;
                m_first = last;
                m_len   = 0;
            end
        end
        @(negedge clk_pcie);
        check_value("tlps_rx_valid", tlps_rx_valid, exp_valid);
        if (exp_valid && tlps_rx_valid) begin
            for (int i = 0; i < 4; i++) begin
                mask[32*i +: 32] = {32{exp_beat.keepdw[i]}};
            end
            check_value("tlps_rx.data", tlps_rx.data & mask, exp_beat.data & mask);
            check_value("tlps_rx.keepdw", tlps_rx.keepdw, exp_beat.keepdw);
            check_value("tlps_rx.last", tlps_rx.last, exp_beat.last);
            check_value("tlps_rx.user", tlps_rx.user, exp_beat.user);
        end
        exp_valid = next_valid;
        exp_beat  = next_beat;
    endtask

    task automatic rx_idle(input logic [1:0] req);
        rx_cycle(1'b0, 1, 64'd0, 1'b0, 7'd0, req);
    endtask

    task automatic send_rx_packet(input int ndw, input logic allow_idle);
        logic [6:0] bar_hit;
        int         left;
        int         k;
        left = ndw;
        while (left > 0) begin
            if (allow_idle && lfsr_bit() && lfsr_bit()) begin
                rx_idle(2'b00);
            end else begin
                // Output beat reports the BAR hit of its latest core beat
                bar_hit = 7'(rand_bits(7));
                k    = (left >= 2 && lfsr_bit()) ? 2 : 1;
                left = left - k;
                rx_cycle(1'b1, k, 64'(rand_bits(64)), left == 0, bar_hit, 2'b00);
            end
        end
    endtask

    // Partial packet, then a reset request, then a clean packet
    task automatic rx_reset_test(input logic [1:0] req, input string name);
        int unsigned err_start;
        int          wait_cnt;
        err_start = errors;
        rx_cycle(1'b1, 2, 64'(rand_bits(64)), 1'b0, 7'h01, 2'b00);
        rx_idle(req);
        clear_rx_model();
        wait_cnt = 0;
        while (i_pcie_tlp_bridge.subsys_rst !== 1'b1 && wait_cnt < 8) begin
            rx_idle(2'b00);
            wait_cnt++;
        end
        if (i_pcie_tlp_bridge.subsys_rst !== 1'b1) begin
            errors++;
            $display("Timeout: subsys_rst never rose after %s", name);
        end
        wait_cnt = 0;
        while (i_pcie_tlp_bridge.subsys_rst !== 1'b0 && wait_cnt < 8) begin
            rx_idle(2'b00);
            wait_cnt++;
        end
        if (i_pcie_tlp_bridge.subsys_rst !== 1'b0) begin
            errors++;
            $display("Timeout: subsys_rst never released after %s", name);
        end
        send_rx_packet(6, 1'b0);
        rx_idle(2'b00);
        rx_idle(2'b00);
        finish_test({"receive reset by ", name}, err_start);
    endtask

    // ------------------------------------------------
    // Transmit path
    // ------------------------------------------------

    task automatic run_tx_test(input int n_beats);
        int unsigned   err_start;
        int            sent;
        int            accepted;
        int            cycles;
        int            ndw;
        logic          take;
        logic          stalled;
        core_tx_beat_t stall_beat;
        core_tx_beat_t exp;
        tlps_beat_t    beat;
        err_start = errors;
        sent      = 0;
        accepted  = 0;
        cycles    = 0;
        take      = 1'b0;
        stalled   = 1'b0;
        while ((accepted < n_beats || tx_exp_q.size() > 0) && cycles < n_beats * 20) begin
            @(posedge clk_pcie);
            if (sent < n_beats && (!tlps_tx_valid || take)) begin
                ndw         = 1 + int'(rand_bits(2));
                beat        = '0;
                beat.data   = rand_bits(128);
                beat.keepdw = 4'((1 << ndw) - 1);
                beat.last   = lfsr_bit();
                tlps_tx       <= beat;
                tlps_tx_valid <= 1'b1;
                sent++;
                // Expected core beats, low qword first
                exp.data = beat.data.qw[0];
                exp.keep = (ndw >= 2) ? 8'hff : 8'h0f;
                exp.last = beat.last && ndw <= 2;
                tx_exp_q.push_back(exp);
                if (ndw > 2) begin
                    exp.data = beat.data.qw[1];
                    exp.keep = (ndw == 4) ? 8'hff : 8'h0f;
                    exp.last = beat.last;
                    tx_exp_q.push_back(exp);
                end
            end else if (take) begin
                tlps_tx_valid <= 1'b0;
            end
            core_tx_ready <= lfsr_bit() | lfsr_bit();
            @(negedge clk_pcie);
            cycles++;
            take = tlps_tx_valid && tlps_tx_ready;
            if (take) begin
                accepted++;
            end
            if (stalled) begin
                check_value("core_tx_valid", core_tx_valid, 1'b1);
                check_value("core_tx", core_tx, stall_beat);
            end
            if (core_tx_valid && core_tx_ready) begin
                if (tx_exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected core_tx beat at %0t ns", $time);
                end else begin
                    exp = tx_exp_q.pop_front();
                    check_value("core_tx.data", core_tx.data, exp.data);
                    check_value("core_tx.keep", core_tx.keep, exp.keep);
                    check_value("core_tx.last", core_tx.last, exp.last);
                end
            end
            stalled    = core_tx_valid && !core_tx_ready;
            stall_beat = core_tx;
        end
        @(posedge clk_pcie);
        tlps_tx_valid <= 1'b0;
        core_tx_ready <= 1'b0;
        if (cycles >= n_beats * 20) begin
            errors++;
            $display("Timeout: transmit beats were not all delivered");
        end
        check_value("accepted beats", accepted, n_beats);
        finish_test("transmit narrowing", err_start);
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------

    initial begin
        int unsigned err_start;
        int          wait_cnt;
        clk_pcie         = 1'b0;
        rst              = 1'b1;
        link_up          = 1'b0;
        user_reset       = 1'b0;
        subsys_reset_req = 1'b0;
        tlps_tx          = '0;
        tlps_tx_valid    = 1'b0;
        core_tx_ready    = 1'b0;
        core_rx          = '0;
        core_rx_valid    = 1'b0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        lfsr      = 16'd97;
        exp_valid = 1'b0;
        exp_beat  = '0;
        clear_rx_model();

        repeat (3) @(posedge clk_pcie);
        rst <= 1'b0;

        err_start = errors;
        @(negedge clk_pcie);
        check_value("core_tx_valid", core_tx_valid, 1'b0);
        check_value("tlps_rx_valid", tlps_rx_valid, 1'b0);
        check_value("led_state", led_state, 1'b0);
        wait_cnt = 0;
        while (i_pcie_tlp_bridge.subsys_rst !== 1'b0 && wait_cnt < 8) begin
            @(negedge clk_pcie);
            wait_cnt++;
        end
        if (i_pcie_tlp_bridge.subsys_rst !== 1'b0) begin
            errors++;
            $display("Timeout: subsys_rst stuck high after reset");
        end
        finish_test("reset state", err_start);

        run_tx_test(80);

        err_start = errors;
        repeat (30) begin
            send_rx_packet(1 + int'(rand_bits(4)) % 12, 1'b1);
        end
        rx_idle(2'b00);
        rx_idle(2'b00);
        finish_test("receive widening", err_start);

        err_start = errors;
        repeat (20) begin
            send_rx_packet(1 + int'(rand_bits(4)) % 12, 1'b0);
        end
        rx_idle(2'b00);
        rx_idle(2'b00);
        finish_test("receive back to back", err_start);

        rx_reset_test(2'b01, "subsys_reset_req");
        rx_reset_test(2'b10, "user_reset");

        // Steady LED while the link is up
        err_start = errors;
        @(posedge clk_pcie);
        link_up <= 1'b1;
        repeat (40) begin
            @(negedge clk_pcie);
            check_value("led_state", led_state, 1'b1);
        end
        @(posedge clk_pcie);
        link_up <= 1'b0;
        finish_test("link up LED", err_start);

        $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
